// ==== common/rv_core_pkg.sv ====
package rv_core_pkg;

  // ========================================
  // Widths and basic types
  // ========================================
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [xlen-1:0] addr_t;
  typedef logic [4:0]      reg_idx_t;

  // addi x0, x0, 0
  localparam word_t nop_instr = 32'h0000_0013;
  localparam addr_t reset_pc  = '0;

  // ========================================
  // Instruction encodings
  // ========================================
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011
  } opcode_e;

  // ALU funct3
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // Selects SUB and SRA
  localparam logic [6:0] f7_alt = 7'b0100000;

  // ========================================
  // Decoded controls
  // ========================================
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_kind_e;

  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       jump;
    logic       alu_src_imm;
    logic       pc_as_a;
    alu_op_e    alu_op;
    logic [2:0] funct3;
  } ctrl_t;

endpackage

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall_i,
  input  logic               hold_i,
  input  logic               redirect_i,
  input  rv_core_pkg::addr_t redirect_pc_i,
  output rv_core_pkg::addr_t imem_addr_o,
  output logic               imem_read_o,
  input  rv_core_pkg::word_t imem_rdata_i,
  input  logic               imem_ready_i,
  output rv_core_pkg::word_t if_instr_o,
  output rv_core_pkg::addr_t if_pc_o,
  output logic               if_valid_o
);
  import rv_core_pkg::*;

  addr_t pc;
  logic  fetch_ok;

  // No request while the load-use bubble is inserted
  assign imem_read_o = !hold_i;
  assign imem_addr_o = pc;
  assign fetch_ok    = imem_read_o && imem_ready_i;

  // Program counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (!stall_i) begin
      if (redirect_i) begin
        pc <= redirect_pc_i;
      end else if (fetch_ok) begin
        pc <= pc + addr_t'(4);
      end
    end
  end

  // IF/ID register, wrong-path word dropped on redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_valid_o <= 1'b0;
      if_instr_o <= nop_instr;
    end else if (!stall_i) begin
      if (redirect_i) begin
        if_valid_o <= 1'b0;
      end else if (fetch_ok) begin
        if_valid_o <= 1'b1;
        if_instr_o <= imem_rdata_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i && !redirect_i && fetch_ok) begin
      if_pc_o <= pc;
    end
  end

endmodule

// ==== execute/decode_ctrl.sv ====
`timescale 1ns/100ps

module decode_ctrl (
  input  rv_core_pkg::word_t    instr_i,
  output rv_core_pkg::ctrl_t    ctrl_o,
  output rv_core_pkg::word_t    imm_o,
  output rv_core_pkg::reg_idx_t rs1_o,
  output rv_core_pkg::reg_idx_t rs2_o,
  output rv_core_pkg::reg_idx_t rd_o
);
  import rv_core_pkg::*;

  logic [2:0] funct3;
  logic       alt;
  logic       use_rs1;
  logic       use_rs2;
  imm_kind_e  imm_kind;
  alu_op_e    f3_op;

  assign funct3 = instr_i[14:12];
  assign alt    = (instr_i[31:25] == f7_alt);

  // ALU operation named by funct3 alone
  always_comb begin
    case (funct3)
      f3_add_sub: f3_op = alu_add;
      f3_sll:     f3_op = alu_sll;
      f3_slt:     f3_op = alu_slt;
      f3_sltu:    f3_op = alu_sltu;
      f3_xor:     f3_op = alu_xor;
      f3_srl_sra: f3_op = alt ? alu_sra : alu_srl;
      f3_or:      f3_op = alu_or;
      f3_and:     f3_op = alu_and;
      default:    f3_op = alu_add;
    endcase
  end

  // ========================================
  // Control fields
  // ========================================
  always_comb begin
    ctrl_o        = '0;
    ctrl_o.funct3 = funct3;
    ctrl_o.alu_op = alu_add;
    imm_kind      = imm_i;
    use_rs1       = 1'b0;
    use_rs2       = 1'b0;
    case (opcode_e'(instr_i[6:0]))
      opc_op: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_op    = (funct3 == f3_add_sub && alt) ? alu_sub : f3_op;
        use_rs1          = 1'b1;
        use_rs2          = 1'b1;
      end
      opc_op_imm: begin
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.alu_op      = f3_op;
        use_rs1            = 1'b1;
      end
      opc_lui: begin
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.alu_op      = alu_pass_b;
        imm_kind           = imm_u;
      end
      opc_auipc: begin
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.pc_as_a     = 1'b1;
        imm_kind           = imm_u;
      end
      opc_jal: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.jump      = 1'b1;
        imm_kind         = imm_j;
      end
      opc_branch: begin
        ctrl_o.branch = 1'b1;
        imm_kind      = imm_b;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
      end
      opc_load: begin
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.mem_read    = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        use_rs1            = 1'b1;
      end
      opc_store: begin
        ctrl_o.mem_write   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        imm_kind           = imm_s;
        use_rs1            = 1'b1;
        use_rs2            = 1'b1;
      end
      // Unknown opcodes keep the cleared controls
      default: ;
    endcase
  end

  // Sign-extended immediate
  always_comb begin
    case (imm_kind)
      imm_s:   imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      imm_b:   imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
      imm_u:   imm_o = {instr_i[31:12], 12'b0};
      imm_j:   imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
      default: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
    endcase
  end

  // Unused source fields read as x0 to avoid false hazards
  assign rs1_o = use_rs1 ? instr_i[19:15] : '0;
  assign rs2_o = use_rs2 ? instr_i[24:20] : '0;
  assign rd_o  = instr_i[11:7];

endmodule

// ==== execute/regfile.sv ====
`timescale 1ns/100ps

module regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_core_pkg::reg_idx_t rs1_i,
  input  rv_core_pkg::reg_idx_t rs2_i,
  output rv_core_pkg::word_t    rs1_data_o,
  output rv_core_pkg::word_t    rs2_data_o,
  input  logic                  we_i,
  input  rv_core_pkg::reg_idx_t rd_i,
  input  rv_core_pkg::word_t    wdata_i
);
  import rv_core_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // Same-cycle write is visible to the reader
  assign rs1_data_o = (rs1_i == '0) ? '0 : (we_i && rd_i == rs1_i) ? wdata_i : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : (we_i && rd_i == rs2_i) ? wdata_i : regs[rs2_i];

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall_i,
  input  rv_core_pkg::word_t    if_instr_i,
  input  rv_core_pkg::addr_t    if_pc_i,
  input  logic                  if_valid_i,
  input  logic                  wb_we_i,
  input  rv_core_pkg::reg_idx_t wb_rd_i,
  input  rv_core_pkg::word_t    wb_data_i,
  output logic                  hold_o,
  output logic                  redirect_o,
  output rv_core_pkg::addr_t    redirect_pc_o,
  output rv_core_pkg::ctrl_t    mem_ctrl_o,
  output rv_core_pkg::word_t    mem_result_o,
  output rv_core_pkg::word_t    mem_store_data_o,
  output rv_core_pkg::reg_idx_t mem_rd_o,
  output logic                  mem_valid_o
);
  import rv_core_pkg::*;

  ctrl_t    id_ctrl;
  word_t    id_imm;
  reg_idx_t id_rs1;
  reg_idx_t id_rs2;
  reg_idx_t id_rd;
  word_t    id_rs1_data;
  word_t    id_rs2_data;

  ctrl_t    ex_ctrl;
  logic     ex_valid;
  addr_t    ex_pc;
  word_t    ex_imm;
  word_t    ex_rs1_data;
  word_t    ex_rs2_data;
  reg_idx_t ex_rs1;
  reg_idx_t ex_rs2;
  reg_idx_t ex_rd;

  logic     fwd_mem_ok;
  word_t    op_a;
  word_t    op_b;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_out;
  word_t    ex_result;
  logic     br_taken;

  // ========================================
  // ID stage
  // ========================================
  decode_ctrl i_decode_ctrl (
    .instr_i (if_instr_i),
    .ctrl_o  (id_ctrl),
    .imm_o   (id_imm),
    .rs1_o   (id_rs1),
    .rs2_o   (id_rs2),
    .rd_o    (id_rd)
  );

  regfile i_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_i      (id_rs1),
    .rs2_i      (id_rs2),
    .rs1_data_o (id_rs1_data),
    .rs2_data_o (id_rs2_data),
    .we_i       (wb_we_i),
    .rd_i       (wb_rd_i),
    .wdata_i    (wb_data_i)
  );

  // Load in EX feeding the instruction in ID
  assign hold_o = if_valid_i && ex_valid && ex_ctrl.mem_read && (ex_rd != '0) &&
                  ((ex_rd == id_rs1) || (ex_rd == id_rs2));

  // ID/EX, bubble on hold, flush on redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_ctrl  <= '0;
    end else if (!stall_i) begin
      ex_valid <= if_valid_i && !hold_o && !redirect_o;
      ex_ctrl  <= id_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      ex_pc       <= if_pc_i;
      ex_imm      <= id_imm;
      ex_rs1_data <= id_rs1_data;
      ex_rs2_data <= id_rs2_data;
      ex_rs1      <= id_rs1;
      ex_rs2      <= id_rs2;
      ex_rd       <= id_rd;
    end
  end

  // ========================================
  // EX stage
  // ========================================
  // Load data is not ready in EX/MEM yet
  assign fwd_mem_ok = mem_valid_o && mem_ctrl_o.reg_write && !mem_ctrl_o.mem_read;

  always_comb begin
    if (fwd_mem_ok && ex_rs1 != '0 && mem_rd_o == ex_rs1) begin
      op_a = mem_result_o;
    end else if (wb_we_i && ex_rs1 != '0 && wb_rd_i == ex_rs1) begin
      op_a = wb_data_i;
    end else begin
      op_a = ex_rs1_data;
    end
  end

  always_comb begin
    if (fwd_mem_ok && ex_rs2 != '0 && mem_rd_o == ex_rs2) begin
      op_b = mem_result_o;
    end else if (wb_we_i && ex_rs2 != '0 && wb_rd_i == ex_rs2) begin
      op_b = wb_data_i;
    end else begin
      op_b = ex_rs2_data;
    end
  end

  assign alu_a = ex_ctrl.pc_as_a ? ex_pc : op_a;
  assign alu_b = ex_ctrl.alu_src_imm ? ex_imm : op_b;

  always_comb begin
    case (ex_ctrl.alu_op)
      alu_add:    alu_out = alu_a + alu_b;
      alu_sub:    alu_out = alu_a - alu_b;
      alu_sll:    alu_out = alu_a << alu_b[4:0];
      alu_slt:    alu_out = word_t'($signed(alu_a) < $signed(alu_b));
      alu_sltu:   alu_out = word_t'(alu_a < alu_b);
      alu_xor:    alu_out = alu_a ^ alu_b;
      alu_srl:    alu_out = alu_a >> alu_b[4:0];
      alu_sra:    alu_out = word_t'($signed(alu_a) >>> alu_b[4:0]);
      alu_or:     alu_out = alu_a | alu_b;
      alu_and:    alu_out = alu_a & alu_b;
      alu_pass_b: alu_out = alu_b;
      default:    alu_out = alu_a + alu_b;
    endcase
  end

  // Branch compare on forwarded operands
  always_comb begin
    case (ex_ctrl.funct3)
      f3_beq:  br_taken = (op_a == op_b);
      f3_bne:  br_taken = (op_a != op_b);
      f3_blt:  br_taken = ($signed(op_a) < $signed(op_b));
      f3_bge:  br_taken = ($signed(op_a) >= $signed(op_b));
      f3_bltu: br_taken = (op_a < op_b);
      f3_bgeu: br_taken = (op_a >= op_b);
      default: br_taken = 1'b0;
    endcase
  end

  assign redirect_o    = ex_valid && (ex_ctrl.jump || (ex_ctrl.branch && br_taken));
  assign redirect_pc_o = ex_pc + ex_imm;

  // JAL writes its link address
  assign ex_result = ex_ctrl.jump ? ex_pc + addr_t'(4) : alu_out;

  // EX/MEM register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_valid_o <= 1'b0;
      mem_ctrl_o  <= '0;
    end else if (!stall_i) begin
      mem_valid_o <= ex_valid;
      mem_ctrl_o  <= ex_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      mem_result_o     <= ex_result;
      mem_store_data_o <= op_b;
      mem_rd_o         <= ex_rd;
    end
  end

endmodule

// ==== hw/mem_writeback.sv ====
`timescale 1ns/100ps

module mem_writeback (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_core_pkg::ctrl_t    mem_ctrl_i,
  input  rv_core_pkg::word_t    mem_result_i,
  input  rv_core_pkg::word_t    mem_store_data_i,
  input  rv_core_pkg::reg_idx_t mem_rd_i,
  input  logic                  mem_valid_i,
  output rv_core_pkg::addr_t    dmem_addr_o,
  output rv_core_pkg::word_t    dmem_wdata_o,
  output logic                  dmem_read_o,
  output logic                  dmem_write_o,
  input  rv_core_pkg::word_t    dmem_rdata_i,
  input  logic                  dmem_ready_i,
  output logic                  mem_wait_o,
  output logic                  wb_we_o,
  output rv_core_pkg::reg_idx_t wb_rd_o,
  output rv_core_pkg::word_t    wb_data_o
);
  import rv_core_pkg::*;

  logic access;

  // ========================================
  // Data port
  // ========================================
  // Request held from EX/MEM until ready
  assign dmem_read_o  = mem_valid_i && mem_ctrl_i.mem_read;
  assign dmem_write_o = mem_valid_i && mem_ctrl_i.mem_write;
  assign dmem_addr_o  = mem_result_i;
  assign dmem_wdata_o = mem_store_data_i;

  assign access     = dmem_read_o || dmem_write_o;
  assign mem_wait_o = access && !dmem_ready_i;

  // ========================================
  // MEM/WB register
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_o <= 1'b0;
    end else if (!mem_wait_o) begin
      wb_we_o <= mem_valid_i && mem_ctrl_i.reg_write && (mem_rd_i != '0);
    end
  end

  // Load data taken on the accepting edge
  always_ff @(posedge clk) begin
    if (!mem_wait_o) begin
      wb_rd_o   <= mem_rd_i;
      wb_data_o <= dmem_read_o ? dmem_rdata_i : mem_result_i;
    end
  end

endmodule

// ==== hw/rv_core_top.sv ====
`timescale 1ns/100ps

module rv_core_top (
  input  logic               clk,
  input  logic               rst_n,
  output rv_core_pkg::addr_t imem_addr_o,
  output logic               imem_read_o,
  input  rv_core_pkg::word_t imem_rdata_i,
  input  logic               imem_ready_i,
  output rv_core_pkg::addr_t dmem_addr_o,
  output rv_core_pkg::word_t dmem_wdata_o,
  output logic               dmem_read_o,
  output logic               dmem_write_o,
  input  rv_core_pkg::word_t dmem_rdata_i,
  input  logic               dmem_ready_i
);
  import rv_core_pkg::*;

  logic     stall;
  logic     mem_wait;
  logic     hold;
  logic     redirect;
  addr_t    redirect_pc;
  word_t    if_instr;
  addr_t    if_pc;
  logic     if_valid;
  ctrl_t    mem_ctrl;
  word_t    mem_result;
  word_t    mem_store_data;
  reg_idx_t mem_rd;
  logic     mem_valid;
  logic     wb_we;
  reg_idx_t wb_rd;
  word_t    wb_data;

  // Either memory holding off freezes the whole pipe
  assign stall = (imem_read_o && !imem_ready_i) || mem_wait;

  fetch_unit i_fetch_unit (
    .clk, .rst_n,
    .stall_i       (stall),
    .hold_i        (hold),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_addr_o, .imem_read_o, .imem_rdata_i, .imem_ready_i,
    .if_instr_o    (if_instr),
    .if_pc_o       (if_pc),
    .if_valid_o    (if_valid)
  );

  execute_stage i_execute_stage (
    .clk, .rst_n,
    .stall_i          (stall),
    .if_instr_i       (if_instr),
    .if_pc_i          (if_pc),
    .if_valid_i       (if_valid),
    .wb_we_i          (wb_we),
    .wb_rd_i          (wb_rd),
    .wb_data_i        (wb_data),
    .hold_o           (hold),
    .redirect_o       (redirect),
    .redirect_pc_o    (redirect_pc),
    .mem_ctrl_o       (mem_ctrl),
    .mem_result_o     (mem_result),
    .mem_store_data_o (mem_store_data),
    .mem_rd_o         (mem_rd),
    .mem_valid_o      (mem_valid)
  );

  mem_writeback i_mem_writeback (
    .clk, .rst_n,
    .mem_ctrl_i       (mem_ctrl),
    .mem_result_i     (mem_result),
    .mem_store_data_i (mem_store_data),
    .mem_rd_i         (mem_rd),
    .mem_valid_i      (mem_valid),
    .dmem_addr_o, .dmem_wdata_o, .dmem_read_o, .dmem_write_o,
    .dmem_rdata_i, .dmem_ready_i,
    .mem_wait_o       (mem_wait),
    .wb_we_o          (wb_we),
    .wb_rd_o          (wb_rd),
    .wb_data_o        (wb_data)
  );

endmodule

// ==== verif/program_table.svh ====
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// ========================================
// Test program and expected stores
// ========================================
// x1 = -20, x2 = 7, x10 = store area, x11 = load area
task automatic load_program();
  addr_t pc_here;
  prog_len  = 0;
  store_off = 0;
  emit_word(i_type(-20, 0, 3'b000, 1, 7'b0010011));
  emit_word(i_type(7, 0, 3'b000, 2, 7'b0010011));
  emit_word(i_type(256, 0, 3'b000, 10, 7'b0010011));
  emit_word(i_type(64, 0, 3'b000, 11, 7'b0010011));

  // Register-register ALU, each result stored back to back
  emit_word(r_type(7'h00, 2, 1, 3'b000, 3));
  store_result(3, 32'hFFFF_FFF3);
  emit_word(r_type(7'h20, 2, 1, 3'b000, 3));
  store_result(3, 32'hFFFF_FFE5);
  emit_word(r_type(7'h00, 2, 2, 3'b001, 3));
  store_result(3, 32'h0000_0380);
  emit_word(r_type(7'h00, 2, 1, 3'b010, 3));
  store_result(3, 32'h0000_0001);
  emit_word(r_type(7'h00, 2, 1, 3'b011, 3));
  store_result(3, 32'h0000_0000);
  emit_word(r_type(7'h00, 2, 1, 3'b100, 3));
  store_result(3, 32'hFFFF_FFEB);
  emit_word(r_type(7'h00, 2, 1, 3'b101, 3));
  store_result(3, 32'h01FF_FFFF);
  emit_word(r_type(7'h20, 2, 1, 3'b101, 3));
  store_result(3, 32'hFFFF_FFFF);
  emit_word(r_type(7'h00, 2, 1, 3'b110, 3));
  store_result(3, 32'hFFFF_FFEF);
  emit_word(r_type(7'h00, 2, 1, 3'b111, 3));
  store_result(3, 32'h0000_0004);

  // Immediate forms
  emit_word(i_type(100, 1, 3'b000, 3, 7'b0010011));
  store_result(3, 32'h0000_0050);
  emit_word(i_type(-19, 1, 3'b010, 3, 7'b0010011));
  store_result(3, 32'h0000_0001);
  emit_word(i_type(8, 2, 3'b011, 3, 7'b0010011));
  store_result(3, 32'h0000_0001);
  emit_word(i_type(-1, 2, 3'b100, 3, 7'b0010011));
  store_result(3, 32'hFFFF_FFF8);
  emit_word(i_type(4, 2, 3'b001, 3, 7'b0010011));
  store_result(3, 32'h0000_0070);
  emit_word(i_type(28, 1, 3'b101, 3, 7'b0010011));
  store_result(3, 32'h0000_000F);
  emit_word(i_type(32'h402, 1, 3'b101, 3, 7'b0010011));
  store_result(3, 32'hFFFF_FFFB);
  emit_word(i_type(48, 2, 3'b110, 3, 7'b0010011));
  store_result(3, 32'h0000_0037);
  emit_word(i_type(255, 1, 3'b111, 3, 7'b0010011));
  store_result(3, 32'h0000_00EC);

  // LUI and AUIPC
  emit_word(u_type(20'h12345, 3, 7'b0110111));
  store_result(3, 32'h1234_5000);
  pc_here = addr_t'(prog_len * 4);
  emit_word(u_type(20'h00001, 3, 7'b0010111));
  store_result(3, pc_here + 32'h0000_1000);

  // Dependent chain without gaps, then the same with NOPs
  emit_word(i_type(5, 0, 3'b000, 4, 7'b0010011));
  emit_word(i_type(3, 4, 3'b000, 5, 7'b0010011));
  emit_word(r_type(7'h00, 4, 5, 3'b000, 6));
  store_result(6, 32'd13);
  emit_word(i_type(5, 0, 3'b000, 13, 7'b0010011));
  emit_word(nop_word);
  emit_word(nop_word);
  emit_word(i_type(3, 13, 3'b000, 14, 7'b0010011));
  emit_word(nop_word);
  emit_word(nop_word);
  emit_word(r_type(7'h00, 13, 14, 3'b000, 15));
  emit_word(nop_word);
  emit_word(nop_word);
  store_result(15, 32'd13);

  // Load-use pairs
  emit_word(i_type(0, 11, 3'b010, 7, 7'b0000011));
  load_expected(32'h40);
  emit_word(r_type(7'h00, 2, 7, 3'b000, 8));
  store_result(8, init_word(32'h40) + 32'd7);
  emit_word(i_type(4, 11, 3'b010, 9, 7'b0000011));
  load_expected(32'h44);
  store_result(9, init_word(32'h44));

  // Branches, taken then not taken per kind
  taken_branch(3'b000, 2, 2);
  untaken_branch(3'b000, 1, 2);
  taken_branch(3'b001, 1, 2);
  untaken_branch(3'b001, 2, 2);
  taken_branch(3'b100, 1, 2);
  untaken_branch(3'b100, 2, 1);
  taken_branch(3'b101, 2, 1);
  untaken_branch(3'b101, 1, 2);
  taken_branch(3'b110, 2, 1);
  untaken_branch(3'b110, 1, 2);
  taken_branch(3'b111, 1, 2);
  untaken_branch(3'b111, 2, 1);

  // JAL with link stored, then park in a loop
  pc_here = addr_t'(prog_len * 4);
  emit_word(j_type(12, 12));
  emit_word(s_type(252, 1, 10));
  emit_word(s_type(252, 1, 10));
  store_result(12, pc_here + 32'd4);
  emit_word(j_type(0, 0));
endtask

`endif

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;
  import rv_core_pkg::*;

  localparam word_t nop_word = 32'h0000_0013;

  logic  clk;
  logic  rst_n;
  addr_t imem_addr_o;
  logic  imem_read_o;
  word_t imem_rdata_i;
  logic  imem_ready_i;
  addr_t dmem_addr_o;
  word_t dmem_wdata_o;
  logic  dmem_read_o;
  logic  dmem_write_o;
  word_t dmem_rdata_i;
  logic  dmem_ready_i;

  word_t  prog [0:255];
  word_t  dmem [0:255];
  addr_t  exp_addr[$];
  word_t  exp_data[$];
  addr_t  exp_load[$];
  int     prog_len;
  int     store_off;
  int     store_idx;
  int     load_idx;
  integer seed;
  integer rnd;

  rv_core_top i_rv_core_top (.*);

  // ========================================
  // Instruction encoders
  // ========================================
  function automatic word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                   input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                   input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  // Always a word store
  function automatic word_t s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input int off, input int rs1, input int rs2,
                                   input logic [2:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input int rd,
                                   input logic [6:0] opc);
    return {imm, rd[4:0], opc};
  endfunction

  function automatic word_t j_type(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  // Preset data memory contents
  function automatic word_t init_word(input addr_t a);
    return (a * 32'h9E37_79B9) ^ 32'h5A5A_1234;
  endfunction

  task automatic emit_word(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic store_result(input int rs2, input word_t value);
    emit_word(s_type(store_off, rs2, 10));
    exp_addr.push_back(addr_t'(32'h100 + store_off));
    exp_data.push_back(value);
    store_off += 4;
  endtask

  task automatic load_expected(input addr_t a);
    exp_load.push_back(a);
  endtask

  // Two shadow stores to 0x1FC that must be skipped
  task automatic taken_branch(input logic [2:0] f3, input int rs1, input int rs2);
    emit_word(b_type(12, rs1, rs2, f3));
    emit_word(s_type(252, 1, 10));
    emit_word(s_type(252, 1, 10));
  endtask

  task automatic untaken_branch(input logic [2:0] f3, input int rs1, input int rs2);
    emit_word(b_type(12, rs1, rs2, f3));
    store_result(2, 32'd7);
    emit_word(nop_word);
  endtask

  `include "program_table.svh"

  // ========================================
  // Checks
  // ========================================
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_fetch_addr(input addr_t got);
    if (got !== 32'h0000_0000) begin
      stop_with_failure($sformatf("Mismatch at %0t: first fetch address %h, expected %h",
                                  $time, got, 32'h0000_0000));
    end
  endtask

  task automatic check_store(input addr_t got_addr, input word_t got_data);
    if (store_idx >= exp_addr.size()) begin
      stop_with_failure($sformatf("Unexpected extra store to %h at %0t", got_addr, $time));
    end else if (got_addr !== exp_addr[store_idx] || got_data !== exp_data[store_idx]) begin
      stop_with_failure($sformatf("Mismatch at %0t: store %0d got [%h]=%h, expected [%h]=%h",
                                  $time, store_idx, got_addr, got_data,
                                  exp_addr[store_idx], exp_data[store_idx]));
    end else begin
      store_idx++;
    end
  endtask

  task automatic check_load(input addr_t got_addr, input word_t got_data);
    if (load_idx >= exp_load.size()) begin
      stop_with_failure($sformatf("Unexpected extra load from %h at %0t", got_addr, $time));
    end else if (got_addr !== exp_load[load_idx] || got_data !== init_word(got_addr)) begin
      stop_with_failure($sformatf("Mismatch at %0t: load %0d got [%h]=%h, expected [%h]=%h",
                                  $time, load_idx, got_addr, got_data, exp_load[load_idx],
                                  init_word(exp_load[load_idx])));
    end else begin
      load_idx++;
    end
  endtask

  // ========================================
  // Memory models
  // ========================================
  assign imem_rdata_i = prog[imem_addr_o[9:2]];
  assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];

  always @(posedge clk) begin
    #1;
    rnd          = $random(seed);
    dmem_ready_i = rnd[0];
  end

  // Transfers taken on the accepting edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (dmem_read_o && store_idx == 0) begin
        stop_with_failure("Data read issued before the first program store");
      end
      if (dmem_write_o && dmem_ready_i) begin
        check_store(dmem_addr_o, dmem_wdata_o);
        dmem[dmem_addr_o[9:2]] = dmem_wdata_o;
      end
      if (dmem_read_o && dmem_ready_i) begin
        check_load(dmem_addr_o, dmem_rdata_i);
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog
  initial begin
    @(posedge rst_n);
    repeat (exp_addr.size() * 40) @(posedge clk);
    stop_with_failure("Timeout: the program did not finish its stores in time");
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    seed         = 5;
    rst_n        = 1'b0;
    imem_ready_i = 1'b1;
    dmem_ready_i = 1'b0;
    store_idx    = 0;
    load_idx     = 0;
    for (int i = 0; i < 256; i++) begin
      prog[i] = nop_word;
      dmem[i] = init_word(addr_t'(i * 4));
    end
    load_program();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (!imem_read_o || dmem_read_o || dmem_write_o) begin
      stop_with_failure("Memory strobes are wrong right after reset");
    end
    check_fetch_addr(imem_addr_o);
    wait (store_idx == exp_addr.size());
    // Extra stores would show up here
    repeat (40) @(posedge clk);
    if (load_idx == exp_load.size()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_with_failure("Not every expected load reached the data port");
    end
  end

endmodule

// ==== vlog.f ====
+incdir+verif
common/rv_core_pkg.sv
hw/fetch_unit.sv
execute/decode_ctrl.sv
execute/regfile.sv
execute/execute_stage.sv
hw/mem_writeback.sv
hw/rv_core_top.sv
verif/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module rv_core_tb -o rv_core_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status, see sim.log"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
